// File: include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

`define NOC_PORTS 5
`define FLIT_W 18

// Flit id field, all flits.
`define FLIT_ID_MSB 17
`define FLIT_ID_LSB 15

// Header only.
`define DEST_MSB 14
`define DEST_LSB 12
`define LEN_W 12

`define FIFO_DEPTH 4

`endif

// File: nocRouter.f
+incdir+include
source/nocPkg.sv
source/inputPort.sv
source/portTimer.sv
source/outputArbiter.sv
source/crossbar.sv
source/nocRouter.sv
tb/clockGen.sv
tb/nocRouterTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the nocRouter testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module nocRouterTb -f nocRouter.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: source/crossbar.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module crossbar import nocPkg::*;
(
  input  logic [`NOC_PORTS-1:0][`NOC_PORTS-1:0] grant,     // [output][input]
  input  logic [`NOC_PORTS-1:0][`FLIT_W-1:0]    headFlit,
  input  logic [`NOC_PORTS-1:0]                 notEmpty,
  output logic [`NOC_PORTS-1:0][`FLIT_W-1:0]    outFlit,
  output logic [`NOC_PORTS-1:0]                 outValid,
  output portIdT [`NOC_PORTS-1:0]               outSrc
);

  always_comb
  begin
    for (int q = 0; q < `NOC_PORTS; q++)
    begin
      // One-hot grant to index.
      outSrc[q] = PORT_L;
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (grant[q][p])
          outSrc[q] = portIdT'(p);
      end
      outValid[q] = |(grant[q] & notEmpty);
      outFlit[q] = outValid[q] ? headFlit[outSrc[q]] : '0;
    end
  end

endmodule

`default_nettype wire

// File: source/inputPort.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module inputPort import nocPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FLIT_W-1:0]    inFlit,
  input  logic                  inValid,
  input  logic                  pop,
  output logic                  inFull,
  output logic                  notEmpty,
  output logic [`FLIT_W-1:0]    headFlit,
  output flitIdT                headId,
  output logic [`LEN_W-1:0]     headLen,
  output logic [`NOC_PORTS-1:0] req
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  logic [`FLIT_W-1:0] mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic [`DEST_MSB-`DEST_LSB:0] destReg;
  logic [`DEST_MSB-`DEST_LSB:0] dest;
  logic doWrite;
  logic doRead;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign inFull = (count == CNT_W'(`FIFO_DEPTH));
  assign notEmpty = (count != '0);
  assign doWrite = inValid && !inFull;  // Writes while full are dropped.
  assign doRead = pop && notEmpty;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      destReg <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doRead)
        rdPtr <= nextPtr(rdPtr);
      count <= count + CNT_W'(doWrite) - CNT_W'(doRead);
      // Body and tail follow the header's route.
      if (doRead && headId == FLIT_HEAD)
        destReg <= headFlit[`DEST_MSB:`DEST_LSB];
    end
  end

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  assign headFlit = notEmpty ? mem[rdPtr] : '0;  // Idle flit when empty.
  assign headId = flitIdT'(headFlit[`FLIT_ID_MSB:`FLIT_ID_LSB]);
  assign headLen = headFlit[`LEN_W-1:0];

  // Header at the head routes itself before it is popped.
  assign dest = (headId == FLIT_HEAD) ? headFlit[`DEST_MSB:`DEST_LSB] : destReg;
  assign req = notEmpty ? (`NOC_PORTS'(1) << dest) : '0;

endmodule

`default_nettype wire

// File: source/nocPkg.sv
`default_nettype none

package nocPkg;

  // Port order L, N, E, W, S everywhere.
  typedef enum logic [2:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portIdT;

  typedef enum logic [2:0] {
    FLIT_IDLE = 3'd0,
    FLIT_HEAD = 3'd1,  // Carries dest and length.
    FLIT_BODY = 3'd2,
    FLIT_TAIL = 3'd3
  } flitIdT;

endpackage

`default_nettype wire

// File: source/nocRouter.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module nocRouter import nocPkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic [`NOC_PORTS-1:0][`FLIT_W-1:0] inFlit,
  input  logic [`NOC_PORTS-1:0]             inValid,
  output logic [`NOC_PORTS-1:0]             inFull,
  output logic [`NOC_PORTS-1:0][`FLIT_W-1:0] outFlit,
  output logic [`NOC_PORTS-1:0]             outValid,
  output portIdT [`NOC_PORTS-1:0]           outSrc
);

  logic [`NOC_PORTS-1:0][`NOC_PORTS-1:0] req;        // [input][output]
  logic [`NOC_PORTS-1:0][`NOC_PORTS-1:0] reqT;       // [output][input]
  logic [`NOC_PORTS-1:0][`NOC_PORTS-1:0] grant;      // [output][input]
  logic [`NOC_PORTS-1:0][`NOC_PORTS-1:0] liveGrant;
  logic [`NOC_PORTS-1:0] pop;
  logic [`NOC_PORTS-1:0] notEmpty;
  logic [`NOC_PORTS-1:0][`FLIT_W-1:0] headFlit;
  flitIdT [`NOC_PORTS-1:0] headId;
  logic [`NOC_PORTS-1:0][`LEN_W-1:0] headLen;

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : gInput
    inputPort inPort (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[p]),
      .inValid  (inValid[p]),
      .pop      (pop[p]),
      .inFull   (inFull[p]),
      .notEmpty (notEmpty[p]),
      .headFlit (headFlit[p]),
      .headId   (headId[p]),
      .headLen  (headLen[p]),
      .req      (req[p])
    );
  end

  for (genvar q = 0; q < `NOC_PORTS; q++)
  begin : gOutput
    outputArbiter arbiter (
      .clk     (clk),
      .rst     (rst),
      .req     (reqT[q]),
      .headId  (headId),
      .headLen (headLen),
      .grant   (grant[q])
    );
  end

  // A grant counts only while the input still asks for that output.
  // The registered grant lags a cycle, and a new header may route elsewhere.
  always_comb
  begin
    pop = '0;
    for (int q = 0; q < `NOC_PORTS; q++)
    begin
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        reqT[q][p] = req[p][q];
        liveGrant[q][p] = grant[q][p] && req[p][q];
        pop[p] = pop[p] || liveGrant[q][p];
      end
    end
  end

  crossbar xbar (
    .grant    (liveGrant),
    .headFlit (headFlit),
    .notEmpty (notEmpty),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outSrc   (outSrc)
  );

endmodule

`default_nettype wire

// File: source/outputArbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module outputArbiter import nocPkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic [`NOC_PORTS-1:0]             req,
  input  flitIdT [`NOC_PORTS-1:0]           headId,
  input  logic [`NOC_PORTS-1:0][`LEN_W-1:0] headLen,
  output logic [`NOC_PORTS-1:0]             grant
);

  localparam int STATE_W = `NOC_PORTS + 1;
  localparam logic [STATE_W-1:0] IDLE_STATE = STATE_W'(1);

  logic [STATE_W-1:0] state;
  logic [STATE_W-1:0] nextState;
  logic [`NOC_PORTS-1:0] runTimer;
  logic [`NOC_PORTS-1:0] timeUp;

  // First requester at or after start, wrapping.
  function automatic logic [STATE_W-1:0] rotatePick(
    input logic [`NOC_PORTS-1:0] reqVec,
    input int                    start
  );
    logic [STATE_W-1:0] pick;
    int idx;
    pick = IDLE_STATE;
    for (int n = `NOC_PORTS - 1; n >= 0; n--)
    begin
      idx = (start + n) % `NOC_PORTS;
      if (reqVec[idx])
        pick = STATE_W'(2) << idx;
    end
    return pick;
  endfunction

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : gTimer
    portTimer timer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (headId[p]),
      .length   (headLen[p]),
      .runTimer (runTimer[p]),
      .timeUp   (timeUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE_STATE;
    else
      state <= nextState;
  end

  always_comb
  begin
    runTimer = '0;
    nextState = rotatePick(req, 0);  // Idle, L first.
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      if (state[i+1])
      begin
        if (req[i] && !timeUp[i])
        begin
          runTimer[i] = 1'b1;
          nextState = state;
        end
        else
        begin
          // Owner drops out, search starts after it.
          nextState = rotatePick(req & ~(`NOC_PORTS'(1) << i), (i + 1) % `NOC_PORTS);
        end
      end
    end
  end

  assign grant = state[`NOC_PORTS:1];

endmodule

`default_nettype wire

// File: source/portTimer.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module portTimer import nocPkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  flitIdT            flitId,
  input  logic [`LEN_W-1:0] length,
  input  logic              runTimer,
  output logic              timeUp
);

  logic [`LEN_W-1:0] period;
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      period <= '0;
    end
    else
    begin
      if (flitId == FLIT_HEAD)
        period <= length;  // Latest header wins.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Grant spans count 0..period, so length+1 cycles.
  assign timeUp = (count == period);

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period.
  end

  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/nocRouterTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module nocRouterTb import nocPkg::*;
();

  localparam int N = `NOC_PORTS;
  localparam int FLIT_BUDGET = 160;

  logic clk;
  logic rst;
  logic [N-1:0][`FLIT_W-1:0] inFlit = '0;
  logic [N-1:0] inValid = '0;
  logic [N-1:0] inFull;
  logic [N-1:0][`FLIT_W-1:0] outFlit;
  logic [N-1:0] outValid;
  portIdT [N-1:0] outSrc;
  logic [`FLIT_W-1:0] sendQ [N][$];
  logic [`FLIT_W-1:0] expQ [N*N][$];  // Indexed src*N+dest.
  logic [N-1:0] sent = '0;
  logic [N-1:0] noRetry = '0;
  logic [N-1:0] lastValid = '0;
  logic [N-1:0] contended = '0;  // Another input waited since the last owner's flit.
  logic [N-1:0] lastReq [N];
  int lastSrc [N];
  int run [N];
  int curDest [N];
  int lenOf [N];
  int errors = 0;
  int checks = 0;
  int fillCount;
  int src;
  logic [31:0] rng = 32'he7082c58;
  string testName = "reset";

  clockGen clockSource (.clk(clk), .rst(rst));

  nocRouter i_dut (
    .clk(clk), .rst(rst), .inFlit(inFlit), .inValid(inValid), .inFull(inFull),
    .outFlit(outFlit), .outValid(outValid), .outSrc(outSrc)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Next requester after the owner, wrapping.
  function automatic int nextInRing(input logic [N-1:0] reqs, input int owner);
    for (int k = 1; k < N; k++)
    begin
      if (reqs[(owner + k) % N])
        return (owner + k) % N;
    end
    return owner;
  endfunction

  function automatic bit busy();
    bit b;
    b = (inValid != '0);
    for (int i = 0; i < N * N; i++)
      b = b || (expQ[i].size() != 0) || (i < N && sendQ[i].size() != 0);
    return b;
  endfunction

  task automatic checkEq(input string name, input int expV, input int actV);
    checks++;
    assert (expV == actV)
    else
    begin
      errors++;
      $display("Error: %s expected %0h actual %0h", name, expV, actV);
    end
  endtask

  task automatic queuePacket(input int s, input int dest, input int len, input int nBody);
    sendQ[s].push_back({FLIT_HEAD, 3'(dest), 12'(len)});
    for (int i = 0; i <= nBody; i++)
    begin
      rng = xorshift(rng);
      sendQ[s].push_back({(i == nBody) ? FLIT_TAIL : FLIT_BODY, rng[14:0]});
    end
  endtask

  task automatic drain();
    do @(negedge clk); while (busy());
    repeat (3) @(negedge clk);
  endtask

  // Driver retries a refused flit unless noRetry drops it.
  always @(posedge clk)
  begin
    for (int p = 0; p < N; p++)
    begin
      if (inValid[p] && (sent[p] || noRetry[p]))
        void'(sendQ[p].pop_front());
      inValid[p] <= !rst && sendQ[p].size() != 0;
      inFlit[p] <= (sendQ[p].size() != 0) ? sendQ[p][0] : '0;
    end
  end

  always @(negedge clk)
  begin : monitor
    int s;
    logic [N-1:0] others;
    for (int p = 0; p < N; p++)
    begin
      sent[p] = !rst && inValid[p] && !inFull[p];
      if (sent[p])
      begin
        if (inFlit[p][`FLIT_ID_MSB:`FLIT_ID_LSB] == FLIT_HEAD)
        begin
          curDest[p] = int'(inFlit[p][`DEST_MSB:`DEST_LSB]);
          lenOf[p] = int'(inFlit[p][`LEN_W-1:0]);
        end
        expQ[p*N+curDest[p]].push_back(inFlit[p]);
      end
    end
    for (int q = 0; q < N; q++)
    begin
      if (outValid[q])
      begin
        s = int'(outSrc[q]);
        others = i_dut.reqT[q] & ~(N'(1) << s);
        if (expQ[s*N+q].size() == 0)
        begin
          errors++;
          $display("%s: output %0d sent a flit nobody wrote for it from input %0d",
            testName, q, s);
        end
        else
          checkEq({testName, " flit"}, expQ[s*N+q].pop_front(), outFlit[q]);
        if (lastValid[q] && s == lastSrc[q])
          run[q]++;
        else
        begin
          if (contended[q])
            checkEq({testName, " rotation"}, nextInRing(lastReq[q], lastSrc[q]), s);
          run[q] = 1;
        end
        if (others != '0)
          checkEq({testName, " hold limit"}, 1, int'(run[q] <= lenOf[s] + 1));
        contended[q] = (others != '0);
        lastSrc[q] = s;
      end
      else if ((i_dut.reqT[q] & ~(N'(1) << lastSrc[q])) == '0)
        contended[q] = 1'b0;
      lastValid[q] = outValid[q];
      lastReq[q] = i_dut.reqT[q];
    end
  end

  // Outputs come out of reset quiet.
  assert property (@(posedge clk) $past(rst) |-> (outValid == '0 && inFull == '0))
  else
  begin
    errors++;
    $display("Outputs were not quiet right after reset");
  end

  initial
  begin : watchdog
    #(40 * (FLIT_BUDGET * 20 + 200));
    $display("Watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    for (int i = 0; i < N; i++)
    begin
      curDest[i] = 0;
      lenOf[i] = 0;
      run[i] = 0;
    end
    do @(negedge clk); while (rst);
    checkEq(testName, 0, outValid);
    checkEq(testName, 0, inFull);

    testName = "delivery";
    queuePacket(PORT_L, PORT_E, 10, 2);
    drain();

    testName = "priority";
    for (int p = 0; p < N; p++)
      queuePacket(p, PORT_W, 4, 0);
    do @(negedge clk); while (!outValid[PORT_W]);
    checkEq(testName, PORT_L, outSrc[PORT_W]);
    drain();

    testName = "timeout";
    queuePacket(PORT_L, PORT_S, 3, 10);
    queuePacket(PORT_E, PORT_S, 3, 4);
    drain();

    testName = "backpressure";
    noRetry[PORT_N] = 1'b1;
    queuePacket(PORT_L, PORT_W, 40, 18);
    queuePacket(PORT_N, PORT_W, 40, 7);
    fillCount = 0;
    do
    begin
      @(negedge clk);
      if (inValid[PORT_N] && !inFull[PORT_N])
        fillCount++;
    end
    while (!inFull[PORT_N]);
    checkEq(testName, `FIFO_DEPTH, fillCount);
    drain();
    noRetry = '0;

    testName = "random";
    repeat (20)
    begin
      rng = xorshift(rng);
      src = int'(rng % N);
      queuePacket(src, int'((rng >> 8) % N), 2 + src, int'((rng >> 16) % 3));
    end
    drain();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
